//--- hdl/muldiv_pkg.sv
`default_nettype none

package muldiv_pkg;

    localparam int OP_W = 3;

    // funct3 codes of the M extension
    localparam logic [OP_W-1:0] OP_MUL    = 3'd0;
    localparam logic [OP_W-1:0] OP_MULH   = 3'd1;  // signed x signed, high half
    localparam logic [OP_W-1:0] OP_MULHSU = 3'd2;  // signed x unsigned, high half
    localparam logic [OP_W-1:0] OP_MULHU  = 3'd3;
    localparam logic [OP_W-1:0] OP_DIV    = 3'd4;  // bit 2 marks the divider
    localparam logic [OP_W-1:0] OP_DIVU   = 3'd5;  // bit 0 unsigned
    localparam logic [OP_W-1:0] OP_REM    = 3'd6;  // bit 1 remainder
    localparam logic [OP_W-1:0] OP_REMU   = 3'd7;

endpackage

`default_nettype wire

//--- hdl/muldiv_req_if.sv
`timescale 1ns/100ps
`default_nettype none

interface muldiv_req_if #(
    parameter int SIZE = 32
);

    logic                          start;
    logic [muldiv_pkg::OP_W-1:0]   op;
    logic [SIZE-1:0]               a;
    logic [SIZE-1:0]               b;

    modport issuer (
        output start,
        output op,
        output a,
        output b
    );

    modport engine (
        input start,
        input op,
        input a,
        input b
    );

endinterface

`default_nettype wire

//--- hdl/div_unsigned.sv
`timescale 1ns/100ps
`default_nettype none

module div_unsigned #(
    parameter int SIZE = 32
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            start,
    input  logic [SIZE-1:0] dividend,
    input  logic [SIZE-1:0] divisor,
    output logic [SIZE-1:0] quotient,
    output logic [SIZE-1:0] remainder,
    output logic            busy,
    output logic            done,
    output logic            error
);

    localparam int CNT_W = $clog2(SIZE + 1);

    logic [CNT_W-1:0] count;
    logic [SIZE-1:0]  rem_q;
    logic [SIZE-1:0]  quo_q;   // shifts dividend out, quotient in
    logic [SIZE-1:0]  dsr_q;
    logic [SIZE:0]    trial;
    logic             accept;
    logic             running;

    assign accept  = start && !busy;
    assign running = busy && (count != CNT_W'(SIZE));
    assign trial   = {rem_q, quo_q[SIZE-1]} - {1'b0, dsr_q};  // msb set means borrow

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            error <= 1'b0;
            count <= '0;
        end else if (accept) begin
            busy  <= 1'b1;
            count <= '0;
            error <= (divisor == '0);
        end else if (running) begin
            count <= count + 1'b1;
        end else if (busy && !done) begin
            done <= 1'b1;
        end else if (done) begin
            done <= 1'b0;
            busy <= 1'b0;  // held through done so ready stays low
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            rem_q <= '0;
            quo_q <= dividend;
            dsr_q <= divisor;
        end else if (running) begin
            if (!trial[SIZE]) begin
                rem_q <= trial[SIZE-1:0];
                quo_q <= {quo_q[SIZE-2:0], 1'b1};
            end else begin
                rem_q <= {rem_q[SIZE-2:0], quo_q[SIZE-1]};  // restore
                quo_q <= {quo_q[SIZE-2:0], 1'b0};
            end
        end
    end

    assign quotient  = quo_q;
    assign remainder = rem_q;

endmodule

`default_nettype wire

//--- hdl/div_signed.sv
`timescale 1ns/100ps
`default_nettype none

module div_signed #(
    parameter int SIZE = 32
) (
    input  logic                clk,
    input  logic                rst_n,
    muldiv_req_if.engine        req,
    output logic                busy,
    output logic                done,
    output logic                error,
    output logic [SIZE-1:0]     value
);

    logic            is_signed;
    logic            a_neg;
    logic            b_neg;
    logic            accept;
    logic [SIZE-1:0] mag_a;
    logic [SIZE-1:0] mag_b;
    logic [SIZE-1:0] quo_u;
    logic [SIZE-1:0] rem_u;
    logic [SIZE-1:0] quo_fix;
    logic [SIZE-1:0] rem_fix;
    logic            quo_neg_q;
    logic            rem_neg_q;
    logic            want_rem_q;

    assign accept    = req.start && req.op[2] && !busy;
    assign is_signed = !req.op[0];
    assign a_neg     = is_signed && req.a[SIZE-1];
    assign b_neg     = is_signed && req.b[SIZE-1];
    assign mag_a     = a_neg ? -req.a : req.a;
    assign mag_b     = b_neg ? -req.b : req.b;

    always_ff @(posedge clk) begin
        if (accept) begin
            quo_neg_q  <= a_neg ^ b_neg;
            rem_neg_q  <= a_neg;         // remainder follows dividend sign
            want_rem_q <= req.op[1];
        end
    end

    div_unsigned #(
        .SIZE(SIZE)
    ) div_unsigned_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (req.start && req.op[2]),
        .dividend  (mag_a),
        .divisor   (mag_b),
        .quotient  (quo_u),
        .remainder (rem_u),
        .busy      (busy),
        .done      (done),
        .error     (error)
    );

    // divide by zero keeps the all-ones quotient
    assign quo_fix = (quo_neg_q && !error) ? -quo_u : quo_u;
    assign rem_fix = rem_neg_q ? -rem_u : rem_u;
    assign value   = want_rem_q ? rem_fix : quo_fix;

endmodule

`default_nettype wire

//--- hdl/mul_shift_add.sv
`timescale 1ns/100ps
`default_nettype none

module mul_shift_add #(
    parameter int SIZE = 32
) (
    input  logic                clk,
    input  logic                rst_n,
    muldiv_req_if.engine        req,
    output logic                busy,
    output logic                done,
    output logic [SIZE-1:0]     value
);

    localparam int CNT_W = $clog2(SIZE + 1);

    logic [CNT_W-1:0]  count;
    logic              accept;
    logic              running;
    logic              a_signed;
    logic              b_signed;
    logic              a_neg;
    logic              b_neg;
    logic [SIZE-1:0]   mag_a;
    logic [SIZE-1:0]   mag_b;
    logic [2*SIZE-1:0] mcand_q;
    logic [SIZE-1:0]   mplier_q;
    logic [2*SIZE-1:0] acc_q;
    logic [2*SIZE-1:0] product;
    logic              neg_q;
    logic              low_q;

    assign accept   = req.start && !req.op[2] && !busy;
    assign running  = busy && (count != CNT_W'(SIZE));
    assign a_signed = (req.op == muldiv_pkg::OP_MULH) || (req.op == muldiv_pkg::OP_MULHSU);
    assign b_signed = (req.op == muldiv_pkg::OP_MULH);
    assign a_neg    = a_signed && req.a[SIZE-1];
    assign b_neg    = b_signed && req.b[SIZE-1];
    assign mag_a    = a_neg ? -req.a : req.a;
    assign mag_b    = b_neg ? -req.b : req.b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            done  <= 1'b0;
            count <= '0;
        end else if (accept) begin
            busy  <= 1'b1;
            count <= '0;
        end else if (running) begin
            count <= count + 1'b1;
        end else if (busy && !done) begin
            done <= 1'b1;
        end else if (done) begin
            done <= 1'b0;
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            mcand_q  <= {{SIZE{1'b0}}, mag_a};
            mplier_q <= mag_b;
            acc_q    <= '0;
            neg_q    <= a_neg ^ b_neg;
            low_q    <= (req.op == muldiv_pkg::OP_MUL);
        end else if (running) begin
            if (mplier_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q  <= mcand_q << 1;
            mplier_q <= mplier_q >> 1;  // lsb picks next partial product
        end
    end

    assign product = neg_q ? -acc_q : acc_q;
    assign value   = low_q ? product[SIZE-1:0] : product[2*SIZE-1:SIZE];

endmodule

`default_nettype wire

//--- hdl/muldiv_result_stage.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_result_stage #(
    parameter int SIZE = 32
) (
    input  logic                clk,
    input  logic                rst_n,
    muldiv_req_if.engine        req,
    input  logic                mul_done,
    input  logic                mul_busy,
    input  logic [SIZE-1:0]     mul_value,
    input  logic                div_done,
    input  logic                div_busy,
    input  logic                div_error,
    input  logic [SIZE-1:0]     div_value,
    output logic                ready,
    output logic                done,
    output logic                error,
    output logic [SIZE-1:0]     result
);

    logic is_div_q;
    logic finish;

    assign ready  = !mul_busy && !div_busy;
    assign finish = is_div_q ? div_done : mul_done;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            is_div_q <= 1'b0;
            done     <= 1'b0;
            error    <= 1'b0;
            result   <= '0;
        end else begin
            done <= 1'b0;
            if (req.start && ready) begin
                is_div_q <= req.op[2];  // class of the accepted op
            end
            if (finish) begin
                result <= is_div_q ? div_value : mul_value;
                error  <= is_div_q && div_error;
                done   <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/muldiv_unit.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_unit #(
    parameter int SIZE = 32
) (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          start,
    input  logic [muldiv_pkg::OP_W-1:0]   op,
    input  logic [SIZE-1:0]               a,
    input  logic [SIZE-1:0]               b,
    output logic                          ready,
    output logic                          done,
    output logic                          error,
    output logic [SIZE-1:0]               result
);

    logic            mul_done;
    logic            mul_busy;
    logic [SIZE-1:0] mul_value;
    logic            div_done;
    logic            div_busy;
    logic            div_error;
    logic [SIZE-1:0] div_value;

    muldiv_req_if #(.SIZE(SIZE)) req ();

    assign req.start = start && ready;  // no start while either engine runs
    assign req.op    = op;
    assign req.a     = a;
    assign req.b     = b;

    mul_shift_add #(
        .SIZE(SIZE)
    ) mul_shift_add_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .busy  (mul_busy),
        .done  (mul_done),
        .value (mul_value)
    );

    div_signed #(
        .SIZE(SIZE)
    ) div_signed_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .req   (req),
        .busy  (div_busy),
        .done  (div_done),
        .error (div_error),
        .value (div_value)
    );

    muldiv_result_stage #(
        .SIZE(SIZE)
    ) muldiv_result_stage_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .req       (req),
        .mul_done  (mul_done),
        .mul_busy  (mul_busy),
        .mul_value (mul_value),
        .div_done  (div_done),
        .div_busy  (div_busy),
        .div_error (div_error),
        .div_value (div_value),
        .ready     (ready),
        .done      (done),
        .error     (error),
        .result    (result)
    );

endmodule

`default_nettype wire

//--- tests/muldiv_tb.sv
`timescale 1ns/100ps
`default_nettype none

module muldiv_tb;

    localparam int SIZE       = 32;
    localparam int CLK_PERIOD = 4;
    localparam int NUM_OPS    = 141;
    localparam logic [SIZE-1:0] MIN = {1'b1, {(SIZE-1){1'b0}}};

    logic                        clk;
    logic                        rst_n;
    logic                        start;
    logic [muldiv_pkg::OP_W-1:0] op;
    logic [SIZE-1:0]             a;
    logic [SIZE-1:0]             b;
    logic                        ready;
    logic                        done;
    logic                        error;
    logic [SIZE-1:0]             result;

    logic [SIZE-1:0] exp_result;
    logic            exp_error;
    logic            pending;  // an op is in flight
    string           test_name;
    integer          seed;
    int              pass_count;
    int              fail_count;
    logic [SIZE-1:0] edge_vals [4] = '{0, 1, {SIZE{1'b1}}, MIN};
    string op_names [8] = '{"MUL", "MULH", "MULHSU", "MULHU", "DIV", "DIVU", "REM", "REMU"};

    muldiv_unit #(.SIZE(SIZE)) muldiv_unit_inst (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // expected {error, result} from double-width arithmetic
    function automatic logic [SIZE:0] ref_model(input logic [2:0] f, input logic [SIZE-1:0] x,
                                                input logic [SIZE-1:0] y);
        logic signed [2*SIZE-1:0] sx;
        logic signed [2*SIZE-1:0] sy;
        logic signed [2*SIZE-1:0] ux;
        logic signed [2*SIZE-1:0] uy;
        logic signed [2*SIZE-1:0] w;
        sx = {{SIZE{x[SIZE-1]}}, x};
        sy = {{SIZE{y[SIZE-1]}}, y};
        ux = {{SIZE{1'b0}}, x};
        uy = {{SIZE{1'b0}}, y};
        if (f[2] && y == '0)
            return {1'b1, f[1] ? x : {SIZE{1'b1}}};  // rem keeps dividend
        if (f == muldiv_pkg::OP_DIV && x == MIN && y == '1)
            return {1'b0, MIN};
        if (f == muldiv_pkg::OP_REM && x == MIN && y == '1)
            return {1'b0, {SIZE{1'b0}}};
        case (f)
            muldiv_pkg::OP_MUL, muldiv_pkg::OP_MULH: w = sx * sy;
            muldiv_pkg::OP_MULHSU: w = sx * uy;
            muldiv_pkg::OP_MULHU:  w = ux * uy;
            muldiv_pkg::OP_DIV:    w = sx / sy;  // truncates toward zero
            muldiv_pkg::OP_DIVU:   w = ux / uy;
            muldiv_pkg::OP_REM:    w = sx % sy;
            default:               w = ux % uy;
        endcase
        return {1'b0, (f == muldiv_pkg::OP_MUL || f[2]) ? w[SIZE-1:0] : w[2*SIZE-1:SIZE]};
    endfunction

    task automatic run_op(input string name, input logic [2:0] f, input logic [SIZE-1:0] x,
                          input logic [SIZE-1:0] y, input int stray_at);
        logic [SIZE:0] expv;
        int            cyc;
        @(negedge clk);
        assert (ready) else begin
            fail_count++;
            $display("%s: ready was low before the start", name);
        end
        expv       = ref_model(f, x, y);
        exp_result = expv[SIZE-1:0];
        exp_error  = expv[SIZE];
        test_name  = name;
        pending    = 1'b1;
        start      = 1'b1;
        op         = f;
        a          = x;
        b          = y;
        @(negedge clk);
        start = 1'b0;
        cyc   = 0;
        while (!done && cyc < SIZE + 10) begin
            @(negedge clk);
            cyc++;
            if (stray_at > 0 && cyc == stray_at) begin
                start = 1'b1;  // other engine, busy unit
                op    = f ^ 3'b100;
                a     = $random(seed);
                b     = $random(seed);
            end
            if (stray_at > 0 && cyc == stray_at + 3)
                start = 1'b0;
            if (!done) begin
                assert (!ready) else begin
                    fail_count++;
                    $display("%s: ready was high while an engine was busy", name);
                end
            end
        end
        assert (done && cyc == SIZE + 2) else begin
            fail_count++;
            $display("FAIL %s latency expected %0d actual %0d", name, SIZE + 2, cyc);
        end
    endtask

    always @(negedge clk) begin
        if (rst_n && done) begin
            assert (pending) else begin
                fail_count++;
                $display("done pulsed with no operation in flight");
            end
            pending = 1'b0;
            assert (result === exp_result && error === exp_error) begin
                pass_count++;
                $display("PASS %s", test_name);
            end else begin
                fail_count++;
                $display("FAIL %s expected %h err %b actual %h err %b", test_name,
                         exp_result, exp_error, result, error);
            end
        end
    end

    initial begin
        #(NUM_OPS * (SIZE + 8) * CLK_PERIOD);
        $display("timeout: the run went past its time limit and the DUT looks stuck");
        $display("Test failures found");
        $finish;
    end

    initial begin
        logic [SIZE-1:0] x;
        logic [SIZE-1:0] y;
        seed       = 32'h58d5;
        pass_count = 0;
        fail_count = 0;
        pending    = 1'b0;
        rst_n      = 1'b0;
        start      = 1'b0;
        op         = '0;
        a          = '0;
        b          = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        assert (ready && !done && !error && result == '0) else begin
            fail_count++;
            $display("outputs not at their idle values after reset");
        end
        for (int f = 0; f < 4; f++) begin
            for (int i = 0; i < 16; i++)
                run_op($sformatf("%s edge %0d", op_names[f], i), 3'(f),
                       edge_vals[i / 4], edge_vals[i % 4], 0);
            for (int n = 0; n < 6; n++)
                run_op($sformatf("%s random %0d", op_names[f], n), 3'(f),
                       $random(seed), $random(seed), 0);
        end
        for (int n = 0; n < 12; n++) begin
            x = $random(seed);
            y = ($random(seed) & 32'h0000_ffff) | 1;
            x = n[0] ? -{1'b0, x[SIZE-2:0]} : {1'b0, x[SIZE-2:0]};  // sign combo from n
            y = n[1] ? -y : y;
            run_op($sformatf("DIV signed %0d", n), muldiv_pkg::OP_DIV, x, y, 0);
            run_op($sformatf("REM signed %0d", n), muldiv_pkg::OP_REM, x, y, 0);
        end
        for (int n = 0; n < 6; n++) begin
            x = $random(seed);
            y = ($random(seed) >> (n * 4)) | 1;
            run_op($sformatf("DIVU random %0d", n), muldiv_pkg::OP_DIVU, x, y, 0);
            run_op($sformatf("REMU random %0d", n), muldiv_pkg::OP_REMU, x, y, 0);
        end
        for (int f = 4; f < 8; f++) begin
            for (int i = 1; i < 4; i++)
                run_op($sformatf("%s by zero %0d", op_names[f], i), 3'(f), edge_vals[i], '0, 0);
        end
        // divider error level is still high here
        run_op("MUL after div by zero", muldiv_pkg::OP_MUL, MIN, '1, 0);
        run_op("DIV overflow", muldiv_pkg::OP_DIV, MIN, '1, 0);
        run_op("REM overflow", muldiv_pkg::OP_REM, MIN, '1, 0);
        run_op("MULHU stray start", muldiv_pkg::OP_MULHU, $random(seed), $random(seed), 5);
        run_op("REM stray start", muldiv_pkg::OP_REM, $random(seed), 32'd977, 5);
        repeat (SIZE + 4) @(negedge clk);  // an extra done would show up here
        $display("passed %0d, failed %0d, operations %0d", pass_count, fail_count, NUM_OPS);
        if (fail_count == 0 && pass_count == NUM_OPS)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- project.f
hdl/muldiv_pkg.sv
hdl/muldiv_req_if.sv
hdl/div_unsigned.sv
hdl/div_signed.sv
hdl/mul_shift_add.sv
hdl/muldiv_result_stage.sv
hdl/muldiv_unit.sv
tests/muldiv_tb.sv

//--- Bender.yml
package:
  name: muldiv

sources:
  - hdl/muldiv_pkg.sv
  - hdl/muldiv_req_if.sv
  - hdl/div_unsigned.sv
  - hdl/div_signed.sv
  - hdl/mul_shift_add.sv
  - hdl/muldiv_result_stage.sv
  - hdl/muldiv_unit.sv
  - target: test
    files:
      - tests/muldiv_tb.sv
